/* rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// First fetch address
`define RV_RESET_PC 32'h0000_0000

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

/* rv_pkg.sv */
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        MEM_NONE, MEM_LOAD, MEM_STORE
    } mem_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_JAL, BR_JALR
    } br_op_t;

    // One register write that has not reached the register file yet
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        alu_op_t   alu_op;
        mem_op_t   mem_op;
        br_op_t    br_op;
        logic      use_imm;
        logic      use_pc;
        logic      we;
        reg_addr_t rd;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        word_t     result;
        word_t     store_data;
        mem_op_t   mem_op;
        logic      we;
        reg_addr_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     inst;
        word_t     result;
        logic      we;
        reg_addr_t rd;
    } mem_wb_t;

    // Replace a register value when a pending write targets it
    function automatic word_t fwd_select(reg_addr_t idx, word_t value, fwd_t fwd);
        return (fwd.we && fwd.rd == idx && idx != '0) ? fwd.data : value;
    endfunction

endpackage

/* regs.sv */
`timescale 1ns/10ps

module regs import rv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2,
    output word_t     regs_value [NUM_REGS]
);

    // No storage behind x0
    word_t [NUM_REGS-1:1] mem;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem <= '0;
        end else if (we && waddr != '0) begin
            mem[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : mem[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : mem[raddr2];

    always_comb begin
        regs_value[0] = '0;
        for (int i = 1; i < NUM_REGS; i++) begin
            regs_value[i] = mem[i];
        end
    end

    a_x0_write_ignored: assert property (
        @(posedge clk) disable iff (rst) (we && waddr == '0) |=> $stable(mem));

endmodule

/* fetch.sv */
`timescale 1ns/10ps
`include "rv_defs.svh"

module fetch import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   advance,
    input  logic   jump,
    input  word_t  jump_target,
    output logic   ireq_valid,
    output word_t  ireq_addr,
    input  logic   iresp_valid,
    input  word_t  iresp_data,
    output if_id_t if_id_next,
    output logic   ok
);

    word_t pc;
    word_t held_word;
    logic  boot;
    logic  want;
    logic  pending;
    logic  held;
    logic  discard;
    logic  arrive;

    // Wrong-path responses are dropped
    assign arrive = iresp_valid && !discard;

    // One request in flight, so a new one waits out any discarded response
    assign ireq_valid = want && !pending;
    assign ireq_addr = pc;

    // A redirect does not need the current word
    assign ok = held || arrive || jump;

    always_comb begin
        if_id_next.valid = held || arrive;
        if_id_next.pc = pc;
        if_id_next.inst = held ? held_word : iresp_data;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= `RV_RESET_PC;
            boot <= 1'b1;
            want <= 1'b0;
            pending <= 1'b0;
            held <= 1'b0;
            discard <= 1'b0;
        end else begin
            boot <= 1'b0;
            if (boot || advance) begin
                want <= 1'b1;
            end else if (ireq_valid) begin
                want <= 1'b0;
            end
            if (ireq_valid) begin
                pending <= 1'b1;
            end else if (iresp_valid) begin
                pending <= 1'b0;
            end
            if (advance) begin
                pc <= jump ? jump_target : pc + 32'd4;
                held <= 1'b0;
                discard <= (pending && !iresp_valid) || ireq_valid;
            end else begin
                if (arrive) begin
                    held <= 1'b1;
                end
                if (iresp_valid) begin
                    discard <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arrive) begin
            held_word <= iresp_data;
        end
    end

    a_resp_has_req: assert property (
        @(posedge clk) disable iff (rst) iresp_valid |-> pending);

endmodule

/* decoder.sv */
`timescale 1ns/10ps

module decoder import rv_pkg::*; (
    input  if_id_t    if_id,
    input  word_t     rdata1,
    input  word_t     rdata2,
    input  fwd_t      wb_fwd,
    output reg_addr_t raddr1,
    output reg_addr_t raddr2,
    output id_ex_t    id_ex_next
);

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    word_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    arith_op;

    assign inst = if_id.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign raddr1 = inst[19:15];
    assign raddr2 = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Common to OP and OP-IMM; sub exists only in OP
    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == OPC_OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b110: arith_op = ALU_OR;
            3'b111: arith_op = ALU_AND;
            default: arith_op = inst[30] ? ALU_SRA : ALU_SRL;
        endcase
    end

    always_comb begin
        id_ex_next = '0;
        id_ex_next.valid = if_id.valid;
        id_ex_next.pc = if_id.pc;
        id_ex_next.inst = inst;
        id_ex_next.rs1 = raddr1;
        id_ex_next.rs2 = raddr2;
        // Same-cycle writeback would otherwise be missed by the read
        id_ex_next.rs1_val = fwd_select(raddr1, rdata1, wb_fwd);
        id_ex_next.rs2_val = fwd_select(raddr2, rdata2, wb_fwd);
        id_ex_next.rd = inst[11:7];
        id_ex_next.alu_op = ALU_ADD;
        id_ex_next.mem_op = MEM_NONE;
        id_ex_next.br_op = BR_NONE;
        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                id_ex_next.alu_op = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                id_ex_next.use_pc = (opcode == OPC_AUIPC);
                id_ex_next.use_imm = 1'b1;
                id_ex_next.imm = imm_u;
                id_ex_next.we = 1'b1;
            end
            OPC_JAL: begin
                id_ex_next.br_op = BR_JAL;
                id_ex_next.imm = imm_j;
                id_ex_next.we = 1'b1;
            end
            OPC_JALR: begin
                id_ex_next.br_op = BR_JALR;
                id_ex_next.imm = imm_i;
                id_ex_next.we = 1'b1;
            end
            OPC_BRANCH: begin
                id_ex_next.imm = imm_b;
                case (funct3)
                    3'b000: id_ex_next.br_op = BR_BEQ;
                    3'b001: id_ex_next.br_op = BR_BNE;
                    3'b100: id_ex_next.br_op = BR_BLT;
                    3'b101: id_ex_next.br_op = BR_BGE;
                    default: id_ex_next.br_op = BR_NONE;
                endcase
            end
            OPC_LOAD: begin
                // Word access only
                if (funct3 == 3'b010) begin
                    id_ex_next.mem_op = MEM_LOAD;
                    id_ex_next.use_imm = 1'b1;
                    id_ex_next.imm = imm_i;
                    id_ex_next.we = 1'b1;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b010) begin
                    id_ex_next.mem_op = MEM_STORE;
                    id_ex_next.use_imm = 1'b1;
                    id_ex_next.imm = imm_s;
                end
            end
            OPC_OPIMM, OPC_OP: begin
                id_ex_next.alu_op = arith_op;
                id_ex_next.use_imm = (opcode == OPC_OPIMM);
                id_ex_next.imm = imm_i;
                id_ex_next.we = 1'b1;
            end
            default: begin
                id_ex_next.we = 1'b0;
            end
        endcase
    end

endmodule

/* execute.sv */
`timescale 1ns/10ps

module execute import rv_pkg::*; (
    input  id_ex_t  id_ex,
    input  fwd_t    mem_fwd,
    input  fwd_t    wb_fwd,
    output ex_mem_t ex_mem_next,
    output logic    jump,
    output word_t   jump_target
);

    word_t op1;
    word_t op2;
    word_t a;
    word_t b;
    word_t alu_out;
    logic  taken;
    logic  is_jump;

    // Younger result wins
    assign op1 = fwd_select(id_ex.rs1, fwd_select(id_ex.rs1, id_ex.rs1_val, wb_fwd), mem_fwd);
    assign op2 = fwd_select(id_ex.rs2, fwd_select(id_ex.rs2, id_ex.rs2_val, wb_fwd), mem_fwd);

    assign a = id_ex.use_pc ? id_ex.pc : op1;
    assign b = id_ex.use_imm ? id_ex.imm : op2;

    always_comb begin
        case (id_ex.alu_op)
            ALU_SUB:    alu_out = a - b;
            ALU_AND:    alu_out = a & b;
            ALU_OR:     alu_out = a | b;
            ALU_XOR:    alu_out = a ^ b;
            ALU_SLT:    alu_out = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   alu_out = {31'b0, a < b};
            ALU_SLL:    alu_out = a << b[4:0];
            ALU_SRL:    alu_out = a >> b[4:0];
            ALU_SRA:    alu_out = $signed(a) >>> b[4:0];
            ALU_PASS_B: alu_out = b;
            default:    alu_out = a + b;
        endcase
    end

    assign is_jump = (id_ex.br_op == BR_JAL) || (id_ex.br_op == BR_JALR);

    always_comb begin
        case (id_ex.br_op)
            BR_BEQ:  taken = (op1 == op2);
            BR_BNE:  taken = (op1 != op2);
            BR_BLT:  taken = $signed(op1) < $signed(op2);
            BR_BGE:  taken = $signed(op1) >= $signed(op2);
            BR_JAL:  taken = 1'b1;
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump = id_ex.valid && taken;
    assign jump_target = (id_ex.br_op == BR_JALR) ? ((op1 + id_ex.imm) & ~32'd1)
                                                  : (id_ex.pc + id_ex.imm);

    always_comb begin
        ex_mem_next.valid = id_ex.valid;
        ex_mem_next.pc = id_ex.pc;
        ex_mem_next.inst = id_ex.inst;
        // Link address for jumps
        ex_mem_next.result = is_jump ? id_ex.pc + 32'd4 : alu_out;
        ex_mem_next.store_data = op2;
        ex_mem_next.mem_op = id_ex.mem_op;
        ex_mem_next.we = id_ex.we;
        ex_mem_next.rd = id_ex.rd;
    end

endmodule

/* memory.sv */
`timescale 1ns/10ps

module memory import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    advance,
    input  ex_mem_t ex_mem,
    output logic    dreq_valid,
    output logic    dreq_write,
    output word_t   dreq_addr,
    output word_t   dreq_wdata,
    input  logic    dresp_valid,
    input  word_t   dresp_rdata,
    output mem_wb_t mem_wb_next,
    output fwd_t    mem_fwd,
    output logic    ok
);

    logic  active;
    logic  issued;
    logic  done;
    logic  is_load;
    word_t rdata_q;
    word_t load_data;

    assign active = ex_mem.valid && ex_mem.mem_op != MEM_NONE;
    assign is_load = ex_mem.mem_op == MEM_LOAD;

    assign dreq_valid = active && !issued;
    assign dreq_write = ex_mem.mem_op == MEM_STORE;
    assign dreq_addr = ex_mem.result;
    assign dreq_wdata = ex_mem.store_data;

    assign ok = !active || done || dresp_valid;

    // Response data is usable in its own cycle
    assign load_data = dresp_valid ? dresp_rdata : rdata_q;

    always_comb begin
        mem_wb_next.valid = ex_mem.valid;
        mem_wb_next.pc = ex_mem.pc;
        mem_wb_next.inst = ex_mem.inst;
        mem_wb_next.result = is_load ? load_data : ex_mem.result;
        mem_wb_next.we = ex_mem.we;
        mem_wb_next.rd = ex_mem.rd;
    end

    // A load forwards nothing until its data is here
    assign mem_fwd.we = ex_mem.valid && ex_mem.we && (!is_load || done || dresp_valid);
    assign mem_fwd.rd = ex_mem.rd;
    assign mem_fwd.data = mem_wb_next.result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issued <= 1'b0;
            done <= 1'b0;
        end else if (advance) begin
            issued <= 1'b0;
            done <= 1'b0;
        end else begin
            if (dreq_valid) begin
                issued <= 1'b1;
            end
            if (dresp_valid) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dresp_valid) begin
            rdata_q <= dresp_rdata;
        end
    end

    a_dreq_strobe: assert property (
        @(posedge clk) disable iff (rst) dreq_valid |=> !dreq_valid);

endmodule

/* writeback.sv */
`timescale 1ns/10ps

module writeback import rv_pkg::*; (
    input  mem_wb_t   mem_wb,
    input  logic      advance,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output fwd_t      wb_fwd,
    output logic      retire_valid,
    output word_t     retire_pc,
    output word_t     retire_inst
);

    logic writes;

    assign writes = mem_wb.valid && mem_wb.we && mem_wb.rd != '0;

    // Commit only on the edge that moves the pipeline
    assign rf_we = writes && advance;
    assign rf_waddr = mem_wb.rd;
    assign rf_wdata = mem_wb.result;

    assign wb_fwd.we = writes;
    assign wb_fwd.rd = mem_wb.rd;
    assign wb_fwd.data = mem_wb.result;

    assign retire_valid = mem_wb.valid && advance;
    assign retire_pc = mem_wb.pc;
    assign retire_inst = mem_wb.inst;

endmodule

/* rv_core.sv */
`timescale 1ns/10ps
`include "rv_defs.svh"

module rv_core import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    output logic      ireq_valid,
    output word_t     ireq_addr,
    input  logic      iresp_valid,
    input  word_t     iresp_data,
    output logic      dreq_valid,
    output logic      dreq_write,
    output word_t     dreq_addr,
    output word_t     dreq_wdata,
    input  logic      dresp_valid,
    input  word_t     dresp_rdata,
    output logic      retire_valid,
    output word_t     retire_pc,
    output word_t     retire_inst,
    output logic      rf_we,
    output reg_addr_t rf_waddr,
    output word_t     rf_wdata,
    output word_t     regs_value [`RV_NUM_REGS]
);

    if_id_t    if_id;
    if_id_t    if_id_next;
    id_ex_t    id_ex;
    id_ex_t    id_ex_next;
    ex_mem_t   ex_mem;
    ex_mem_t   ex_mem_next;
    mem_wb_t   mem_wb;
    mem_wb_t   mem_wb_next;
    logic      fetch_ok;
    logic      memory_ok;
    logic      advance;
    logic      jump;
    word_t     jump_target;
    fwd_t      mem_fwd;
    fwd_t      wb_fwd;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;

    function automatic if_id_t if_id_bubble();
        if_id_t r;
        r = '0;
        r.inst = `RV_NOP;
        return r;
    endfunction

    function automatic id_ex_t id_ex_bubble();
        id_ex_t r;
        r = '0;
        r.inst = `RV_NOP;
        return r;
    endfunction

    function automatic ex_mem_t ex_mem_bubble();
        ex_mem_t r;
        r = '0;
        r.inst = `RV_NOP;
        return r;
    endfunction

    function automatic mem_wb_t mem_wb_bubble();
        mem_wb_t r;
        r = '0;
        r.inst = `RV_NOP;
        return r;
    endfunction

    // Decode and execute never stall
    assign advance = fetch_ok && memory_ok;

    regs #(.NUM_REGS(`RV_NUM_REGS)) u_regs (
        .clk(clk), .rst(rst),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata),
        .raddr1(raddr1), .raddr2(raddr2),
        .rdata1(rdata1), .rdata2(rdata2),
        .regs_value(regs_value)
    );

    fetch u_fetch (
        .clk(clk), .rst(rst), .advance(advance),
        .jump(jump), .jump_target(jump_target),
        .ireq_valid(ireq_valid), .ireq_addr(ireq_addr),
        .iresp_valid(iresp_valid), .iresp_data(iresp_data),
        .if_id_next(if_id_next), .ok(fetch_ok)
    );

    decoder u_decoder (
        .if_id(if_id), .rdata1(rdata1), .rdata2(rdata2), .wb_fwd(wb_fwd),
        .raddr1(raddr1), .raddr2(raddr2), .id_ex_next(id_ex_next)
    );

    execute u_execute (
        .id_ex(id_ex), .mem_fwd(mem_fwd), .wb_fwd(wb_fwd),
        .ex_mem_next(ex_mem_next), .jump(jump), .jump_target(jump_target)
    );

    memory u_memory (
        .clk(clk), .rst(rst), .advance(advance), .ex_mem(ex_mem),
        .dreq_valid(dreq_valid), .dreq_write(dreq_write),
        .dreq_addr(dreq_addr), .dreq_wdata(dreq_wdata),
        .dresp_valid(dresp_valid), .dresp_rdata(dresp_rdata),
        .mem_wb_next(mem_wb_next), .mem_fwd(mem_fwd), .ok(memory_ok)
    );

    writeback u_writeback (
        .mem_wb(mem_wb), .advance(advance),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .wb_fwd(wb_fwd), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .retire_inst(retire_inst)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id <= if_id_bubble();
            id_ex <= id_ex_bubble();
            ex_mem <= ex_mem_bubble();
            mem_wb <= mem_wb_bubble();
        end else if (advance) begin
            // Taken redirect squashes the two younger stages
            if_id <= jump ? if_id_bubble() : if_id_next;
            id_ex <= jump ? id_ex_bubble() : id_ex_next;
            ex_mem <= ex_mem_next;
            mem_wb <= mem_wb_next;
        end
    end

endmodule

/* tb_rv_core.sv */
`timescale 1ns/10ps
`include "rv_defs.svh"

module tb_rv_core import rv_pkg::*; ();

    localparam int PROG_MAX = 16;
    localparam int WATCHDOG_CYCLES = 200 * PROG_MAX * 4;
    localparam word_t SELF_JUMP = 32'h0000_006f;

    logic      clk;
    logic      rst;
    logic      ireq_valid;
    word_t     ireq_addr;
    logic      iresp_valid;
    word_t     iresp_data;
    logic      dreq_valid;
    logic      dreq_write;
    word_t     dreq_addr;
    word_t     dreq_wdata;
    logic      dresp_valid;
    word_t     dresp_rdata;
    logic      retire_valid;
    word_t     retire_pc;
    word_t     retire_inst;
    logic      rf_we;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;
    word_t     regs_value [`RV_NUM_REGS];

    word_t     imem [256];
    word_t     dmem [256];
    word_t     gmem [256];
    word_t     greg [32];
    word_t     prog [$];
    word_t     exp_pc [$];
    word_t     exp_inst [$];
    reg_addr_t exp_rd [$];
    word_t     exp_data [$];
    integer    seed;
    int        errors;
    int        tests_failed;
    int        i_cnt;
    int        d_cnt;
    word_t     i_addr;

    rv_core DUT (.*);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        iresp_valid = 1'b0;
        iresp_data = '0;
        dresp_valid = 1'b0;
        dresp_rdata = '0;
        seed = 32'h423d_fd80;
        errors = 0;
        tests_failed = 0;
        i_cnt = 0;
        d_cnt = 0;
        i_addr = '0;
    end

    always #4 clk = ~clk;

    // Instruction bus answers after 1 to 3 cycles
    always @(posedge clk) begin
        iresp_valid <= 1'b0;
        if (rst) begin
            i_cnt <= 0;
        end else if (ireq_valid) begin
            i_cnt <= 1 + ($unsigned($random(seed)) % 3);
            i_addr <= ireq_addr;
        end else if (i_cnt > 0) begin
            if (i_cnt == 1) begin
                iresp_valid <= 1'b1;
                iresp_data <= imem[i_addr[9:2]];
            end
            i_cnt <= i_cnt - 1;
        end
    end

    // Data bus with stores landing at request time
    always @(posedge clk) begin
        dresp_valid <= 1'b0;
        if (rst) begin
            d_cnt <= 0;
        end else if (dreq_valid) begin
            d_cnt <= 1 + ($unsigned($random(seed)) % 3);
            if (dreq_write) begin
                dmem[dreq_addr[9:2]] <= dreq_wdata;
            end else begin
                dresp_rdata <= dmem[dreq_addr[9:2]];
            end
        end else if (d_cnt > 0) begin
            if (d_cnt == 1) begin
                dresp_valid <= 1'b1;
            end
            d_cnt <= d_cnt - 1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    function automatic word_t enc_i(word_t imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic word_t enc_s(word_t imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(word_t imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_u(word_t imm, reg_addr_t rd, logic [6:0] op);
        return {imm[19:0], rd, op};
    endfunction

    function automatic word_t enc_j(word_t imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg(string name, reg_addr_t got, reg_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic word_t golden_alu(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Reference interpreter that stops at the self-jump
    task automatic golden_run();
        word_t pc;
        word_t inst;
        word_t nxt;
        word_t res;
        word_t v1;
        word_t v2;
        word_t imm_i;
        word_t imm_b;
        logic  wr;
        logic  take;
        int    n;
        pc = `RV_RESET_PC;
        n = 0;
        foreach (greg[k]) greg[k] = '0;
        while (n < 4 * PROG_MAX && imem[pc[9:2]] != SELF_JUMP) begin
            inst = imem[pc[9:2]];
            v1 = greg[inst[19:15]];
            v2 = greg[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            nxt = pc + 4;
            wr = 1'b0;
            res = '0;
            case (inst[6:0])
                7'h37: begin
                    res = {inst[31:12], 12'b0};
                    wr = 1'b1;
                end
                7'h17: begin
                    res = pc + {inst[31:12], 12'b0};
                    wr = 1'b1;
                end
                7'h6f: begin
                    res = pc + 4;
                    wr = 1'b1;
                    nxt = pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                inst[30:21], 1'b0};
                end
                7'h67: begin
                    res = pc + 4;
                    wr = 1'b1;
                    nxt = (v1 + imm_i) & ~32'd1;
                end
                7'h63: begin
                    case (inst[14:12])
                        3'd0: take = v1 == v2;
                        3'd1: take = v1 != v2;
                        3'd4: take = $signed(v1) < $signed(v2);
                        3'd5: take = $signed(v1) >= $signed(v2);
                        default: take = 1'b0;
                    endcase
                    if (take) nxt = pc + imm_b;
                end
                7'h03: begin
                    res = gmem[(v1 + imm_i) >> 2 & 255];
                    wr = 1'b1;
                end
                7'h23: gmem[(v1 + {{20{inst[31]}}, inst[31:25], inst[11:7]}) >> 2 & 255] = v2;
                7'h13: begin
                    res = golden_alu(inst[14:12], inst[14:12] == 3'd5 && inst[30], v1, imm_i);
                    wr = 1'b1;
                end
                7'h33: begin
                    res = golden_alu(inst[14:12], inst[30], v1, v2);
                    wr = 1'b1;
                end
                default: wr = 1'b0;
            endcase
            wr = wr && inst[11:7] != 0;
            if (wr) greg[inst[11:7]] = res;
            exp_pc.push_back(pc);
            exp_inst.push_back(inst);
            exp_rd.push_back(wr ? inst[11:7] : 5'd0);
            exp_data.push_back(res);
            pc = nxt;
            n++;
        end
    endtask

    task automatic reset_and_check();
        int waited;
        @(posedge clk);
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (ireq_valid || dreq_valid || retire_valid || rf_we) begin
            $display("A strobe is high during reset at %0t", $time);
            errors++;
        end
        foreach (regs_value[k]) check_word($sformatf("regs_value[%0d]", k), regs_value[k], '0);
        @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ireq_valid && waited < 10);
        if (!ireq_valid) begin
            $display("No instruction request after reset release");
            errors++;
        end
        check_word("ireq_addr", ireq_addr, `RV_RESET_PC);
    endtask

    task automatic run_program(string name);
        int errs_before;
        int waited;
        int n;
        errs_before = errors;
        @(posedge clk);
        rst <= 1'b1;
        for (int k = 0; k < 256; k++) begin
            imem[k] = enc_i(k, 0, 0, 0, 7'h13);
            dmem[k] = 32'hd000_0000 | k;
            gmem[k] = 32'hd000_0000 | k;
        end
        foreach (prog[k]) imem[k] = prog[k];
        imem[prog.size()] = SELF_JUMP;
        exp_pc.delete();
        exp_inst.delete();
        exp_rd.delete();
        exp_data.delete();
        golden_run();
        reset_and_check();
        n = 0;
        while (n < exp_pc.size()) begin
            waited = 0;
            do begin
                if (waited > 0 || n > 0) @(negedge clk);
                waited++;
            end while (!retire_valid && waited < 200);
            if (!retire_valid) begin
                $display("%s: no retire within 200 cycles for entry %0d", name, n);
                errors++;
                break;
            end
            check_word("retire_pc", retire_pc, exp_pc[n]);
            check_word("retire_inst", retire_inst, exp_inst[n]);
            check_reg("rf_waddr", rf_we ? rf_waddr : 5'd0, exp_rd[n]);
            if (exp_rd[n] != 0) check_word("rf_wdata", rf_wdata, exp_data[n]);
            n++;
        end
        @(negedge clk);
        foreach (greg[k]) check_word($sformatf("regs_value[%0d]", k), regs_value[k], greg[k]);
        if (errors != errs_before) tests_failed++;
        $display("%s: %0d retires checked, %0d errors", name, n, errors - errs_before);
    endtask

    task automatic alu_test();
        prog = {};
        prog.push_back(enc_i(-5, 0, 0, 1, 7'h13));
        prog.push_back(enc_i(3, 0, 0, 2, 7'h13));
        prog.push_back(enc_r(7'h20, 2, 1, 0, 3));
        prog.push_back(enc_r(0, 2, 1, 2, 4));
        prog.push_back(enc_r(0, 2, 1, 3, 5));
        prog.push_back(enc_r(0, 2, 1, 1, 6));
        prog.push_back(enc_r(0, 2, 1, 5, 7));
        prog.push_back(enc_r(7'h20, 2, 1, 5, 8));
        prog.push_back(enc_i(32'h401, 1, 5, 9, 7'h13));
        prog.push_back(enc_r(0, 2, 1, 4, 10));
        prog.push_back(enc_i(12, 1, 7, 11, 7'h13));
        prog.push_back(enc_i(-16, 2, 6, 12, 7'h13));
        prog.push_back(enc_u(32'h12345, 13, 7'h37));
        prog.push_back(enc_u(1, 14, 7'h17));
        prog.push_back(enc_i(7, 1, 0, 0, 7'h13));
        run_program("alu");
    endtask

    task automatic forwarding_test();
        prog = {};
        prog.push_back(enc_i(7, 0, 0, 1, 7'h13));
        prog.push_back(enc_r(0, 1, 1, 0, 2));
        prog.push_back(enc_r(0, 1, 2, 0, 3));
        prog.push_back(enc_i(9, 0, 0, 4, 7'h13));
        prog.push_back(`RV_NOP);
        prog.push_back(enc_r(0, 3, 4, 0, 5));
        prog.push_back(enc_r(7'h20, 2, 5, 0, 6));
        run_program("forwarding");
    endtask

    task automatic load_store_test();
        prog = {};
        prog.push_back(enc_i(32'h40, 0, 0, 1, 7'h13));
        prog.push_back(enc_i(-123, 0, 0, 2, 7'h13));
        prog.push_back(enc_s(8, 2, 1));
        prog.push_back(enc_i(8, 1, 2, 3, 7'h03));
        prog.push_back(enc_r(0, 2, 3, 0, 4));
        prog.push_back(enc_s(0, 4, 1));
        prog.push_back(enc_i(0, 1, 2, 5, 7'h03));
        prog.push_back(enc_i(1, 5, 0, 6, 7'h13));
        run_program("load_store");
    endtask

    task automatic branch_test();
        prog = {};
        prog.push_back(enc_i(5, 0, 0, 1, 7'h13));
        prog.push_back(enc_i(5, 0, 0, 2, 7'h13));
        prog.push_back(enc_b(8, 2, 1, 0));
        prog.push_back(enc_i(1, 0, 0, 3, 7'h13));
        prog.push_back(enc_b(8, 2, 1, 1));
        prog.push_back(enc_i(-1, 0, 0, 4, 7'h13));
        prog.push_back(enc_b(8, 1, 4, 4));
        prog.push_back(enc_i(2, 0, 0, 5, 7'h13));
        prog.push_back(enc_b(8, 1, 4, 5));
        prog.push_back(enc_j(8, 6));
        prog.push_back(enc_i(3, 0, 0, 7, 7'h13));
        prog.push_back(enc_i(56, 0, 0, 8, 7'h13));
        prog.push_back(enc_i(0, 8, 0, 9, 7'h67));
        prog.push_back(enc_i(4, 0, 0, 10, 7'h13));
        prog.push_back(enc_i(0, 9, 0, 11, 7'h13));
        run_program("branch");
    endtask

    initial begin
        alu_test();
        forwarding_test();
        load_store_test();
        branch_test();
        $display("Tests run 4, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
rv_pkg.sv
regs.sv
fetch.sv
decoder.sv
execute.sv
memory.sv
writeback.sv
rv_core.sv
tb_rv_core.sv

/* run.sh */
#!/bin/sh
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_rv_core -o sim_tb
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
